// ==== design/rv_exec_macros.svh ====
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// data and address width
`define XLEN 32

// register file index width
`define REG_ADDR_W 5

// bytes per instruction, for the link address
`define INS_STEP 4

`endif

// ==== design/rv_exec_pkg.sv ====
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    // base opcodes handled by the execute stage
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // what the commit stage does with the instruction
    typedef enum logic [2:0] {
        CK_NONE,
        CK_ALU,
        CK_LINK,
        CK_LOAD,
        CK_STORE,
        CK_BRANCH
    } ctrl_kind_e;

    typedef struct packed {
        logic [`XLEN-1:0]      ins_addr;
        opcode_e               opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      rs1_data;
        logic [`XLEN-1:0]      rs2_data;
        logic [`REG_ADDR_W-1:0] rd_addr;
    } dec_fields_t;

    typedef struct packed {
        alu_op_e          op;
        logic [`XLEN-1:0] operand_a;
        logic [`XLEN-1:0] operand_b;
    } alu_req_t;

    typedef struct packed {
        ctrl_kind_e             kind;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [2:0]             funct3;
        // branch taken when alu result is zero
        logic                   take_on_zero;
        logic [`XLEN-1:0]       target_addr;
        logic [`XLEN-1:0]       link_addr;
        logic [`XLEN-1:0]       store_src;
    } ctrl_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic             flag;
        logic [`XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic             en;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } mem_wr_t;

endpackage

// ==== design/rv_decode.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_decode (
    input  rv_exec_pkg::dec_fields_t dec_i,
    output rv_exec_pkg::alu_req_t    alu_req_o,
    output rv_exec_pkg::ctrl_t       ctrl_o
);
    import rv_exec_pkg::*;

    always_comb
    begin
        alu_req_o.op        = ALU_ADD;
        alu_req_o.operand_a = dec_i.rs1_data;
        alu_req_o.operand_b = dec_i.imm;

        ctrl_o.kind         = CK_NONE;
        ctrl_o.rd_addr      = dec_i.rd_addr;
        ctrl_o.funct3       = dec_i.funct3;
        ctrl_o.take_on_zero = 1'b0;
        ctrl_o.target_addr  = dec_i.ins_addr + dec_i.imm;
        ctrl_o.link_addr    = dec_i.ins_addr + `XLEN'(`INS_STEP);
        ctrl_o.store_src    = dec_i.rs2_data;

        case (dec_i.opcode)
            OP_IMM:
            begin
                ctrl_o.kind = CK_ALU;
                case (dec_i.funct3)
                    3'b000: alu_req_o.op = ALU_ADD;
                    3'b001: alu_req_o.op = ALU_SLL;
                    3'b010: alu_req_o.op = ALU_SLT;
                    3'b011: alu_req_o.op = ALU_SLTU;
                    3'b100: alu_req_o.op = ALU_XOR;
                    // srai carries funct7 bit 5
                    3'b101: alu_req_o.op = dec_i.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: alu_req_o.op = ALU_OR;
                    default: alu_req_o.op = ALU_AND;
                endcase
            end
            OP_REG:
            begin
                ctrl_o.kind = CK_ALU;
                alu_req_o.operand_b = dec_i.rs2_data;
                case ({dec_i.funct7, dec_i.funct3})
                    10'b0000000_000: alu_req_o.op = ALU_ADD;
                    10'b0100000_000: alu_req_o.op = ALU_SUB;
                    10'b0000000_001: alu_req_o.op = ALU_SLL;
                    10'b0000000_010: alu_req_o.op = ALU_SLT;
                    10'b0000000_011: alu_req_o.op = ALU_SLTU;
                    10'b0000000_100: alu_req_o.op = ALU_XOR;
                    10'b0000000_101: alu_req_o.op = ALU_SRL;
                    10'b0100000_101: alu_req_o.op = ALU_SRA;
                    10'b0000000_110: alu_req_o.op = ALU_OR;
                    10'b0000000_111: alu_req_o.op = ALU_AND;
                    default: ctrl_o.kind = CK_NONE;
                endcase
            end
            // rs1 is expected to be x0 here
            OP_LUI:
            begin
                ctrl_o.kind = CK_ALU;
            end
            OP_AUIPC:
            begin
                ctrl_o.kind = CK_ALU;
                alu_req_o.operand_a = dec_i.ins_addr;
            end
            OP_JAL:
            begin
                ctrl_o.kind = CK_LINK;
                alu_req_o.operand_a = dec_i.ins_addr;
            end
            OP_JALR:
            begin
                ctrl_o.kind = CK_LINK;
            end
            OP_BRANCH:
            begin
                ctrl_o.kind = CK_BRANCH;
                alu_req_o.operand_b = dec_i.rs2_data;
                // eq/ne via sub, lt/ge via slt(u)
                case (dec_i.funct3)
                    3'b000:
                    begin
                        alu_req_o.op = ALU_SUB;
                        ctrl_o.take_on_zero = 1'b1;
                    end
                    3'b001: alu_req_o.op = ALU_SUB;
                    3'b100: alu_req_o.op = ALU_SLT;
                    3'b101:
                    begin
                        alu_req_o.op = ALU_SLT;
                        ctrl_o.take_on_zero = 1'b1;
                    end
                    3'b110: alu_req_o.op = ALU_SLTU;
                    3'b111:
                    begin
                        alu_req_o.op = ALU_SLTU;
                        ctrl_o.take_on_zero = 1'b1;
                    end
                    default: ctrl_o.kind = CK_NONE;
                endcase
            end
            OP_LOAD:  ctrl_o.kind = CK_LOAD;
            OP_STORE: ctrl_o.kind = CK_STORE;
            default:  ctrl_o.kind = CK_NONE;
        endcase
    end

endmodule

// ==== design/rv_alu.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_alu (
    input  rv_exec_pkg::alu_req_t req_i,
    output logic [`XLEN-1:0]      res_o,
    output logic                  zero_o
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = req_i.operand_b[4:0];
    assign lt_s  = $signed(req_i.operand_a) < $signed(req_i.operand_b);
    assign lt_u  = req_i.operand_a < req_i.operand_b;

    always_comb
    begin
        case (req_i.op)
            ALU_ADD:  res_o = req_i.operand_a + req_i.operand_b;
            ALU_SUB:  res_o = req_i.operand_a - req_i.operand_b;
            ALU_SLL:  res_o = req_i.operand_a << shamt;
            ALU_SLT:  res_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res_o = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  res_o = req_i.operand_a ^ req_i.operand_b;
            ALU_SRL:  res_o = req_i.operand_a >> shamt;
            ALU_SRA:  res_o = $unsigned($signed(req_i.operand_a) >>> shamt);
            ALU_OR:   res_o = req_i.operand_a | req_i.operand_b;
            ALU_AND:  res_o = req_i.operand_a & req_i.operand_b;
            default:  res_o = '0;
        endcase
    end

    // branches read this flag
    assign zero_o = (res_o == '0);

endmodule

// ==== design/rv_lsu_align.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_lsu_align (
    input  logic [2:0]       funct3_i,
    input  logic [1:0]       byte_off_i,
    input  logic [`XLEN-1:0] mem_word_i,
    input  logic [`XLEN-1:0] store_src_i,
    output logic [`XLEN-1:0] load_data_o,
    output logic [`XLEN-1:0] store_data_o
);
    import rv_exec_pkg::*;

    logic [4:0]       byte_sh;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [`XLEN-1:0] byte_mask;
    logic [`XLEN-1:0] byte_ins;
    logic [`XLEN-1:0] shifted;

    assign byte_sh = {byte_off_i, 3'b000};
    assign shifted = mem_word_i >> byte_sh;
    assign ld_byte = shifted[7:0];

    // halfword lanes are only 0 or 2
    assign ld_half = (byte_off_i == 2'b00) ? mem_word_i[15:0] : mem_word_i[31:16];

    always_comb
    begin
        case (funct3_i)
            3'b000:  load_data_o = {{24{ld_byte[7]}}, ld_byte};
            3'b001:  load_data_o = {{16{ld_half[15]}}, ld_half};
            3'b100:  load_data_o = {24'h0, ld_byte};
            3'b101:  load_data_o = {16'h0, ld_half};
            default: load_data_o = mem_word_i;
        endcase
    end

    // new byte dropped into the old word
    assign byte_mask = `XLEN'(8'hff) << byte_sh;
    assign byte_ins  = `XLEN'(store_src_i[7:0]) << byte_sh;

    always_comb
    begin
        case (funct3_i)
            3'b000:
            begin
                store_data_o = (mem_word_i & ~byte_mask) | byte_ins;
            end
            3'b001:
            begin
                if (byte_off_i == 2'b00)
                begin
                    store_data_o = {mem_word_i[31:16], store_src_i[15:0]};
                end
                else
                begin
                    store_data_o = {store_src_i[15:0], mem_word_i[15:0]};
                end
            end
            default: store_data_o = store_src_i;
        endcase
    end

endmodule

// ==== design/rv_commit.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_commit (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_exec_pkg::ctrl_t    ctrl_i,
    input  logic [`XLEN-1:0]      alu_res_i,
    input  logic                  alu_zero_i,
    input  logic [`XLEN-1:0]      load_data_i,
    input  logic [`XLEN-1:0]      store_data_i,
    input  logic [`XLEN-1:0]      mem_addr_i,
    output rv_exec_pkg::wb_t      wb_o,
    output rv_exec_pkg::jump_t    jump_o,
    output logic                  hold_o,
    output rv_exec_pkg::mem_wr_t  mem_wr_o
);
    import rv_exec_pkg::*;

    wb_t     wb_nxt;
    jump_t   jump_nxt;
    mem_wr_t mem_nxt;

    always_comb
    begin
        wb_nxt   = '0;
        jump_nxt = '0;
        mem_nxt  = '0;

        case (ctrl_i.kind)
            CK_ALU:
            begin
                wb_nxt = '{en: 1'b1, addr: ctrl_i.rd_addr, data: alu_res_i};
            end
            CK_LINK:
            begin
                wb_nxt   = '{en: 1'b1, addr: ctrl_i.rd_addr, data: ctrl_i.link_addr};
                jump_nxt = '{flag: 1'b1, addr: alu_res_i};
            end
            CK_LOAD:
            begin
                wb_nxt = '{en: 1'b1, addr: ctrl_i.rd_addr, data: load_data_i};
            end
            CK_STORE:
            begin
                mem_nxt = '{en: 1'b1, addr: mem_addr_i, data: store_data_i};
            end
            CK_BRANCH:
            begin
                if (alu_zero_i == ctrl_i.take_on_zero)
                begin
                    jump_nxt = '{flag: 1'b1, addr: ctrl_i.target_addr};
                end
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wb_o     <= '0;
            jump_o   <= '0;
            hold_o   <= 1'b0;
            mem_wr_o <= '0;
        end
        else
        begin
            wb_o     <= wb_nxt;
            jump_o   <= jump_nxt;
            // fetch stalls on every redirect
            hold_o   <= jump_nxt.flag;
            mem_wr_o <= mem_nxt;
        end
    end

endmodule

// ==== design/rv_exec.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_exec (
    input  logic                     clk,
    input  logic                     rst_i,
    input  rv_exec_pkg::dec_fields_t dec_i,
    input  logic [`XLEN-1:0]         mem_rd_addr_i,
    input  logic [`XLEN-1:0]         mem_rd_data_i,
    output rv_exec_pkg::wb_t         wb_o,
    output rv_exec_pkg::jump_t       jump_o,
    output logic                     hold_o,
    output rv_exec_pkg::mem_wr_t     mem_wr_o
);
    import rv_exec_pkg::*;

    alu_req_t         alu_req;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] alu_res;
    logic             alu_zero;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] store_data;

    rv_decode u_decode (
        .dec_i     (dec_i),
        .alu_req_o (alu_req),
        .ctrl_o    (ctrl)
    );

    rv_alu u_alu (
        .req_i  (alu_req),
        .res_o  (alu_res),
        .zero_o (alu_zero)
    );

    // memory word is the aligned one, low address bits pick the lane
    rv_lsu_align u_lsu_align (
        .funct3_i     (ctrl.funct3),
        .byte_off_i   (mem_rd_addr_i[1:0]),
        .mem_word_i   (mem_rd_data_i),
        .store_src_i  (ctrl.store_src),
        .load_data_o  (load_data),
        .store_data_o (store_data)
    );

    rv_commit u_commit (
        .clk          (clk),
        .rst_i        (rst_i),
        .ctrl_i       (ctrl),
        .alu_res_i    (alu_res),
        .alu_zero_i   (alu_zero),
        .load_data_i  (load_data),
        .store_data_i (store_data),
        .mem_addr_i   (mem_rd_addr_i),
        .wb_o         (wb_o),
        .jump_o       (jump_o),
        .hold_o       (hold_o),
        .mem_wr_o     (mem_wr_o)
    );

endmodule

// ==== sim/rv_exec_props.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_exec_props (
    input logic                     clk,
    input logic                     rst_i,
    input rv_exec_pkg::dec_fields_t dec_i,
    input logic [`XLEN-1:0]         mem_rd_addr_i,
    input logic [`XLEN-1:0]         mem_rd_data_i,
    input rv_exec_pkg::wb_t         wb_o,
    input rv_exec_pkg::jump_t       jump_o,
    input logic                     hold_o,
    input rv_exec_pkg::mem_wr_t     mem_wr_o
);
    import rv_exec_pkg::*;

    logic br_taken;

    // branch outcome from the funct3 compare rules
    function automatic logic branch_taken(logic [2:0] f3, logic [`XLEN-1:0] a,
                                          logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    assign br_taken = branch_taken(dec_i.funct3, dec_i.rs1_data, dec_i.rs2_data);

    // outputs quiet on the cycle after reset
    reset_quiet: assert property (@(posedge clk) $past(rst_i) |->
        !wb_o.en && !jump_o.flag && !hold_o && !mem_wr_o.en)
        else $error("outputs active right after reset");

    branch_jump_hold: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i) && $past(dec_i.opcode) == OP_BRANCH
         && $past(dec_i.funct3[2:1]) != 2'b01)
        |-> !wb_o.en && jump_o.flag == $past(br_taken) && hold_o == $past(br_taken))
        else $error("branch jump or hold wrong");

    link_writes_pc4: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i) && ($past(dec_i.opcode) == OP_JAL || $past(dec_i.opcode) == OP_JALR))
        |-> wb_o.en && jump_o.flag && wb_o.data == $past(dec_i.ins_addr) + 32'd4)
        else $error("jump link value or flags wrong");

    store_no_wb: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i) && $past(dec_i.opcode) == OP_STORE)
        |-> mem_wr_o.en && !wb_o.en && mem_wr_o.addr == $past(mem_rd_addr_i))
        else $error("store write enable or address wrong");

    lw_passes_word: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i) && $past(dec_i.opcode) == OP_LOAD && $past(dec_i.funct3) == 3'b010)
        |-> wb_o.en && wb_o.data == $past(mem_rd_data_i))
        else $error("word load data wrong");

endmodule

bind rv_exec rv_exec_props u_props (
    .clk           (clk),
    .rst_i         (rst_i),
    .dec_i         (dec_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .wb_o          (wb_o),
    .jump_o        (jump_o),
    .hold_o        (hold_o),
    .mem_wr_o      (mem_wr_o)
);

// ==== sim/rv_exec_tb.sv ====
`timescale 1ns/1ns

`include "rv_exec_macros.svh"

module rv_exec_tb;
    import rv_exec_pkg::*;

    logic        clk;
    logic        rst_i;
    dec_fields_t dec;
    logic [31:0] mem_addr;
    logic [31:0] mem_data;
    wb_t         wb;
    jump_t       jmp;
    logic        hold;
    mem_wr_t     mwr;
    logic [31:0] rng;
    int          n_pass;
    int          n_fail;

    rv_exec uut (
        .clk           (clk),
        .rst_i         (rst_i),
        .dec_i         (dec),
        .mem_rd_addr_i (mem_addr),
        .mem_rd_data_i (mem_data),
        .wb_o          (wb),
        .jump_o        (jmp),
        .hold_o        (hold),
        .mem_wr_o      (mwr)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                               logic [31:0] b);
        logic [63:0] ext;
        // arithmetic shift as a logical shift of the sign-extended word
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? ext[31:0] : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] extract_load(logic [2:0] f3, logic [1:0] off,
                                                 logic [31:0] w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[off*8 +: 8];
        h = (off == 2'd0) ? w[15:0] : w[31:16];
        case (f3)
            3'd0: return {{24{b[7]}}, b};
            3'd1: return {{16{h[15]}}, h};
            3'd4: return {24'd0, b};
            3'd5: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(logic [2:0] f3, logic [1:0] off,
                                                logic [31:0] w, logic [31:0] s);
        logic [31:0] r;
        r = w;
        if (f3 == 3'd0)
            r[off*8 +: 8] = s[7:0];
        else if (f3 == 3'd1 && off == 2'd0)
            r[15:0] = s[15:0];
        else if (f3 == 3'd1)
            r[31:16] = s[15:0];
        else
            r = s;
        return r;
    endfunction

    // one instruction, then sample at the falling edge after the register
    task automatic issue(opcode_e op, logic [2:0] f3, logic [6:0] f7, logic [31:0] imm,
                         logic [31:0] a, logic [31:0] b, logic [31:0] pc, logic [4:0] rd,
                         logic [31:0] maddr, logic [31:0] mdata);
        @(posedge clk);
        dec <= '{ins_addr: pc, opcode: op, funct3: f3, funct7: f7, imm: imm,
                 rs1_data: a, rs2_data: b, rd_addr: rd};
        mem_addr <= maddr;
        mem_data <= mdata;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check(string name, logic [136:0] exp);
        logic [136:0] act;
        act = {wb, jmp, hold, mwr};
        if (act !== exp)
        begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            n_fail++;
        end
        else
        begin
            $display("ok %s", name);
            n_pass++;
        end
    endtask

    initial
    begin
        #400000;
        $display("timeout: the test sequence did not finish");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] w;
        logic [2:0]  f3;
        logic        alt;
        logic        take;
        clk = 1'b0;
        rst_i = 1'b1;
        dec = '0;
        // live store then jump while in reset, so reset has to mask them
        dec.opcode = OP_STORE;
        mem_addr = '0;
        mem_data = '0;
        rng = 32'd21;
        n_pass = 0;
        n_fail = 0;
        @(posedge clk);
        dec.opcode <= OP_JAL;
        @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check("reset", '0);

        for (int i = 0; i < 32; i++)
        begin
            a = xorshift();
            b = xorshift();
            pc = xorshift();
            f3 = i[2:0];
            alt = i[3] && (f3 == 3'd5 || (i[4] && f3 == 3'd0));
            if (i[4])
                issue(OP_REG, f3, alt ? 7'h20 : 7'h00, 32'd0, a, b, pc, pc[4:0], 0, 0);
            else
                issue(OP_IMM, f3, alt ? 7'h20 : 7'h00, b, a, 32'd0, pc, pc[4:0], 0, 0);
            check($sformatf("alu %0d", i), {1'b1, pc[4:0], alu_result(f3, alt, a, b), 99'd0});
        end

        a = xorshift();
        pc = xorshift();
        issue(OP_LUI, 3'd0, 7'd0, a, 32'd0, 32'd0, pc, 5'd3, 0, 0);
        check("lui", {1'b1, 5'd3, a, 99'd0});
        issue(OP_AUIPC, 3'd0, 7'd0, a, 32'd0, 32'd0, pc, 5'd4, 0, 0);
        check("auipc", {1'b1, 5'd4, pc + a, 99'd0});
        issue(OP_JAL, 3'd0, 7'd0, 32'h40, 32'd0, 32'd0, pc, 5'd1, 0, 0);
        check("jal", {1'b1, 5'd1, pc + 32'd4, 1'b1, pc + 32'h40, 1'b1, 65'd0});
        issue(OP_JALR, 3'd0, 7'd0, 32'h10, a, 32'd0, pc, 5'd1, 0, 0);
        check("jalr", {1'b1, 5'd1, pc + 32'd4, 1'b1, a + 32'h10, 1'b1, 65'd0});

        for (int i = 0; i < 12; i++)
        begin
            f3 = (i < 4) ? 3'(i / 2) : 3'(i / 2 + 2);
            a = xorshift();
            b = xorshift();
            pc = xorshift();
            // unequal pairs go low then high, so lt and ge each get taken once
            if (i[0])
                b = a;
            else if (f3[1] ? (a > b) : ($signed(a) > $signed(b)))
            begin
                w = a;
                a = b;
                b = w;
            end
            case (f3)
                3'd0: take = (a == b);
                3'd1: take = (a != b);
                3'd4: take = $signed(a) < $signed(b);
                3'd5: take = $signed(a) >= $signed(b);
                3'd6: take = a < b;
                default: take = a >= b;
            endcase
            issue(OP_BRANCH, f3, 7'd0, 32'h80, a, b, pc, 5'd0, 0, 0);
            check($sformatf("branch f3=%0d %0d", f3, i[0]),
                  {38'd0, take, take ? pc + 32'h80 : 32'd0, take, 65'd0});
        end

        for (int i = 0; i < 32; i++)
        begin
            f3 = i[4:2];
            a = xorshift();
            w = xorshift();
            b = xorshift();
            a = {a[31:2], i[1:0]};
            if (f3 == 3'd3 || f3 > 3'd5)
                continue;
            issue(OP_LOAD, f3, 7'd0, 32'd0, 32'd0, 32'd0, 32'd0, 5'd9, a, w);
            check($sformatf("load f3=%0d off=%0d", f3, i[1:0]),
                  {1'b1, 5'd9, extract_load(f3, i[1:0], w), 99'd0});
            if (f3 < 3'd3)
            begin
                issue(OP_STORE, f3, 7'd0, 32'd0, 32'd0, b, 32'd0, 5'd0, a, w);
                check($sformatf("store f3=%0d off=%0d", f3, i[1:0]),
                      {72'd0, 1'b1, a, merge_store(f3, i[1:0], w, b)});
            end
        end

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== rv_exec.f ====
+incdir+design
design/rv_exec_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_lsu_align.sv
design/rv_commit.sv
design/rv_exec.sv
sim/rv_exec_props.sv
sim/rv_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rv_exec_tb \
    -f rv_exec.f -o rv_exec_sim || exit 1
out="$(./obj_dir/rv_exec_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx ">>> PASS" && exit 0 || exit 1
